//--- source/vector_io_pkg.sv
//----------------------------------------------------------
// Vector 06C I/O block common definitions
// Port address map, decoded port classes and bus widths
//----------------------------------------------------------

package vector_io_pkg;

	typedef logic [7:0]  port_addr_t;
	typedef logic [7:0]  io_data_t;
	typedef logic [15:0] mem_addr_t;

	//----------------------------------------------------------
	// Port address map
	//----------------------------------------------------------
	localparam port_addr_t ADDR_JOY_CTRL_BIT  = 8'h04;
	localparam port_addr_t ADDR_JOY_CTRL_BYTE = 8'h05;
	localparam port_addr_t ADDR_JOY_P         = 8'h06;
	localparam port_addr_t ADDR_COVOX_PU      = 8'h07;
	localparam port_addr_t ADDR_JOY_A         = 8'h0E;
	localparam port_addr_t ADDR_JOY_B         = 8'h0F;
	localparam port_addr_t ADDR_EDISK         = 8'h10;

	// Decoded port classes
	typedef enum logic [2:0] {
		CLS_NONE     = 3'd0,
		CLS_JOY_CTRL = 3'd1,
		CLS_JOY_P    = 3'd2,
		CLS_COVOX_PU = 3'd3,
		CLS_JOY_A    = 3'd4,
		CLS_JOY_B    = 3'd5,
		CLS_EDISK    = 3'd6
	} port_class_e;

	// Page 0 is main RAM, pages 1..4 are the e-disk banks
	localparam int EDISK_PAGE_W = 3;

	// Floating bus on unmapped reads
	localparam io_data_t READ_IDLE_BYTE = 8'hFF;

endpackage

//--- source/vector_joy_pkg.sv
//----------------------------------------------------------
// Joystick definitions
// Pad bit layout, pad count and P-port select codes
//----------------------------------------------------------

package vector_joy_pkg;

	localparam int PAD_COUNT = 2;

	// One bit per key, set while pressed
	// Bits 6 and 7 carry Fire3 and Fire4, unused by the ports
	typedef logic [7:0] pad_t;

	localparam int PAD_RIGHT = 0;
	localparam int PAD_LEFT  = 1;
	localparam int PAD_DOWN  = 2;
	localparam int PAD_UP    = 3;
	localparam int PAD_FIRE1 = 4;
	localparam int PAD_FIRE2 = 5;

	// Control register bits 6:5
	typedef enum logic [1:0] {
		JOY_SEL_BOTH = 2'b00,
		JOY_SEL_A    = 2'b01,
		JOY_SEL_B    = 2'b10,
		JOY_SEL_NONE = 2'b11
	} joy_sel_e;

endpackage

//--- source/io_bus_frontend.sv
//----------------------------------------------------------
// I/O bus front end
// Holds one request, decodes the port class, pulses the
// write strobe and returns read data on the response channel
//----------------------------------------------------------

module io_bus_frontend import vector_io_pkg::*; (
	input  logic        clk_sys,
	input  logic        cold_reset,

	input  logic        req_valid_i,
	output logic        req_ready_o,
	input  logic        req_write_i,
	input  port_addr_t  req_addr_i,
	input  io_data_t    req_data_i,

	output logic        rsp_valid_o,
	input  logic        rsp_ready_i,
	output io_data_t    rsp_data_o,

	output logic        wr_stb_o,
	output port_class_e wr_class_o,
	output io_data_t    wr_data_o,
	output logic        wr_addr0_o,

	input  io_data_t    joy_p_i,
	input  io_data_t    joy_pu_i,
	input  io_data_t    joy_a_i,
	input  io_data_t    joy_b_i
);

	logic        held_valid_q;
	logic        held_write_q;
	port_addr_t  held_addr_q;
	io_data_t    held_data_q;
	port_class_e held_class;
	io_data_t    read_byte;

	// One transaction in flight at a time
	assign req_ready_o = !held_valid_q && !rsp_valid_o;

	always_comb begin
		case (held_addr_q)
			ADDR_JOY_CTRL_BIT,
			ADDR_JOY_CTRL_BYTE: held_class = CLS_JOY_CTRL;
			ADDR_JOY_P:         held_class = CLS_JOY_P;
			ADDR_COVOX_PU:      held_class = CLS_COVOX_PU;
			ADDR_JOY_A:         held_class = CLS_JOY_A;
			ADDR_JOY_B:         held_class = CLS_JOY_B;
			ADDR_EDISK:         held_class = CLS_EDISK;
			default:            held_class = CLS_NONE;
		endcase
	end

	// Read-back mux
	always_comb begin
		case (held_class)
			CLS_JOY_CTRL: read_byte = 8'h00;
			CLS_JOY_P:    read_byte = joy_p_i;
			CLS_COVOX_PU: read_byte = joy_pu_i;
			CLS_JOY_A:    read_byte = joy_a_i;
			CLS_JOY_B:    read_byte = joy_b_i;
			default:      read_byte = READ_IDLE_BYTE;
		endcase
	end

	//----------------------------------------------------------
	// Control state
	//----------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			held_valid_q <= 1'b0;
			wr_stb_o     <= 1'b0;
			rsp_valid_o  <= 1'b0;
		end else begin
			// Slot clears the cycle after it fills
			held_valid_q <= req_valid_i && req_ready_o;
			wr_stb_o     <= held_valid_q && held_write_q;
			if (held_valid_q && !held_write_q)
				rsp_valid_o <= 1'b1;
			else if (rsp_ready_i)
				rsp_valid_o <= 1'b0;
		end
	end

	// Payload
	always_ff @(posedge clk_sys) begin
		if (req_valid_i && req_ready_o) begin
			held_write_q <= req_write_i;
			held_addr_q  <= req_addr_i;
			held_data_q  <= req_data_i;
		end
		if (held_valid_q && held_write_q) begin
			wr_class_o <= held_class;
			wr_data_o  <= held_data_q;
			wr_addr0_o <= held_addr_q[0];
		end
		if (held_valid_q && !held_write_q)
			rsp_data_o <= read_byte;
	end

endmodule

//--- source/joy_formatter.sv
//----------------------------------------------------------
// Pad formatter
// Samples one pad and builds its active-low P-port byte
//----------------------------------------------------------

module joy_formatter
	import vector_io_pkg::*;
	import vector_joy_pkg::*;
(
	input  logic     clk_sys,
	input  logic     cold_reset,
	input  pad_t     pad_i,
	output io_data_t port_o,
	output pad_t     pad_q_o
);

	always_ff @(posedge clk_sys) begin
		if (cold_reset)
			pad_q_o <= '0;
		else
			pad_q_o <= pad_i;
	end

	// Pressed key reads 0, bits 5:4 are unused and read 1
	assign port_o = ~{pad_q_o[PAD_FIRE2],
	                  pad_q_o[PAD_FIRE1],
	                  2'b00,
	                  pad_q_o[PAD_DOWN],
	                  pad_q_o[PAD_UP],
	                  pad_q_o[PAD_LEFT],
	                  pad_q_o[PAD_RIGHT]};

endmodule

//--- source/joy_port_ctrl.sv
//----------------------------------------------------------
// Joystick port controller
// Control register, P-port pad select and merged PU byte
//----------------------------------------------------------

module joy_port_ctrl
	import vector_io_pkg::*;
	import vector_joy_pkg::*;
(
	input  logic        clk_sys,
	input  logic        cold_reset,

	input  logic        wr_stb_i,
	input  port_class_e wr_class_i,
	input  io_data_t    wr_data_i,
	input  logic        wr_addr0_i,

	input  io_data_t    port_a_i,
	input  io_data_t    port_b_i,
	input  pad_t        pad_a_i,
	input  pad_t        pad_b_i,

	output io_data_t    joy_p_o,
	output io_data_t    joy_pu_o
);

	io_data_t ctrl_q;
	pad_t     pad_or;

	// 05h loads the byte, 04h sets or clears a single bit
	always_ff @(posedge clk_sys) begin
		if (cold_reset) begin
			ctrl_q <= '0;
		end else if (wr_stb_i && wr_class_i == CLS_JOY_CTRL) begin
			if (wr_addr0_i)
				ctrl_q <= wr_data_i;
			else if (!wr_data_i[7])
				ctrl_q[wr_data_i[3:1]] <= wr_data_i[0];
		end
	end

	always_comb begin
		case (joy_sel_e'(ctrl_q[6:5]))
			JOY_SEL_BOTH: joy_p_o = port_a_i & port_b_i;
			JOY_SEL_A:    joy_p_o = port_a_i;
			JOY_SEL_B:    joy_p_o = port_b_i;
			default:      joy_p_o = 8'hFF;
		endcase
	end

	// PU port is active high, both pads merged
	assign pad_or   = pad_a_i | pad_b_i;
	assign joy_pu_o = {pad_or[PAD_UP],
	                   pad_or[PAD_RIGHT],
	                   pad_or[PAD_DOWN],
	                   pad_or[PAD_LEFT],
	                   pad_or[PAD_FIRE1],
	                   pad_or[PAD_FIRE2],
	                   2'b00};

endmodule

//--- source/edisk_mapper.sv
//----------------------------------------------------------
// E-disk mapper
// Turns the CPU address and stack flag into a RAM page
//----------------------------------------------------------

module edisk_mapper import vector_io_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    cold_reset,

	input  logic                    wr_stb_i,
	input  port_class_e             wr_class_i,
	input  io_data_t                wr_data_i,

	input  mem_addr_t               mem_addr_i,
	input  logic                    mem_stack_i,
	input  logic                    mem_access_i,

	output logic [EDISK_PAGE_W-1:0] ed_page_o
);

	io_data_t ed_reg_q;
	logic     upper_hi;
	logic     upper_lo;
	logic     ed_win;
	logic     stack_hit;
	logic     win_hit;

	always_ff @(posedge clk_sys) begin
		if (cold_reset)
			ed_reg_q <= '0;
		else if (wr_stb_i && wr_class_i == CLS_EDISK)
			ed_reg_q <= wr_data_i;
	end

	//----------------------------------------------------------
	// Window decode
	//----------------------------------------------------------
	// A000-DFFF always, E000-FFFF by bit 7, 8000-9FFF by bit 6
	assign upper_hi = mem_addr_i[14] & mem_addr_i[13];
	assign upper_lo = ~mem_addr_i[14] & ~mem_addr_i[13];
	assign ed_win   = mem_addr_i[15] & ((mem_addr_i[14] ^ mem_addr_i[13]) |
	                                    (ed_reg_q[7] & upper_hi) |
	                                    (ed_reg_q[6] & upper_lo));

	assign stack_hit = ed_reg_q[4] & mem_stack_i & mem_access_i;
	assign win_hit   = ed_reg_q[5] & ed_win & mem_access_i;

	// Stack mapping wins over the window
	always_comb begin
		if (stack_hit)
			ed_page_o = EDISK_PAGE_W'(ed_reg_q[3:2]) + EDISK_PAGE_W'(1);
		else if (win_hit)
			ed_page_o = EDISK_PAGE_W'(ed_reg_q[1:0]) + EDISK_PAGE_W'(1);
		else
			ed_page_o = '0;
	end

endmodule

//--- source/covox_dac.sv
//----------------------------------------------------------
// Covox DAC
// 8-bit DAC latch with a write hold-off after reset
// and while the boot ROM is mapped
//----------------------------------------------------------

module covox_dac import vector_io_pkg::*; #(
	parameter int unsigned COVOX_HOLD_CYCLES = 200000000
) (
	input  logic        clk_sys,
	input  logic        cold_reset,
	input  logic        rom_enable_i,
	input  logic        wr_stb_i,
	input  port_class_e wr_class_i,
	input  io_data_t    wr_data_i,
	output io_data_t    covox_o
);

	localparam int HOLD_W = $clog2(COVOX_HOLD_CYCLES + 1);

	logic [HOLD_W-1:0] hold_cnt_q;

	// Reload while held, then run down to zero
	always_ff @(posedge clk_sys) begin
		if (cold_reset || rom_enable_i)
			hold_cnt_q <= HOLD_W'(COVOX_HOLD_CYCLES);
		else if (hold_cnt_q != '0)
			hold_cnt_q <= hold_cnt_q - HOLD_W'(1);
	end

	always_ff @(posedge clk_sys) begin
		if (cold_reset)
			covox_o <= '0;
		else if (wr_stb_i && wr_class_i == CLS_COVOX_PU && hold_cnt_q == '0)
			covox_o <= wr_data_i;
	end

endmodule

//--- source/vector_io_top.sv
//----------------------------------------------------------
// Vector 06C I/O port block
// Bus front end, pad formatters, joystick ports,
// e-disk mapper and covox DAC
//----------------------------------------------------------

module vector_io_top
	import vector_io_pkg::*;
	import vector_joy_pkg::*;
#(
	parameter int unsigned COVOX_HOLD_CYCLES = 200000000
) (
	input  logic                    clk_sys,
	input  logic                    cold_reset,

	input  logic                    req_valid_i,
	output logic                    req_ready_o,
	input  logic                    req_write_i,
	input  port_addr_t              req_addr_i,
	input  io_data_t                req_data_i,

	output logic                    rsp_valid_o,
	input  logic                    rsp_ready_i,
	output io_data_t                rsp_data_o,

	input  pad_t                    pad_a_i,
	input  pad_t                    pad_b_i,

	input  mem_addr_t               mem_addr_i,
	input  logic                    mem_stack_i,
	input  logic                    mem_access_i,
	input  logic                    rom_enable_i,

	output logic [EDISK_PAGE_W-1:0] ed_page_o,
	output io_data_t                covox_o
);

	logic        wr_stb;
	port_class_e wr_class;
	io_data_t    wr_data;
	logic        wr_addr0;
	io_data_t    joy_p;
	io_data_t    joy_pu;

	pad_t        pad_in [PAD_COUNT];
	pad_t        pad_q [PAD_COUNT];
	io_data_t    pad_port [PAD_COUNT];

	assign pad_in[0] = pad_a_i;
	assign pad_in[1] = pad_b_i;

	io_bus_frontend u_io_bus_frontend (
		.clk_sys     (clk_sys),
		.cold_reset  (cold_reset),
		.req_valid_i (req_valid_i),
		.req_ready_o (req_ready_o),
		.req_write_i (req_write_i),
		.req_addr_i  (req_addr_i),
		.req_data_i  (req_data_i),
		.rsp_valid_o (rsp_valid_o),
		.rsp_ready_i (rsp_ready_i),
		.rsp_data_o  (rsp_data_o),
		.wr_stb_o    (wr_stb),
		.wr_class_o  (wr_class),
		.wr_data_o   (wr_data),
		.wr_addr0_o  (wr_addr0),
		.joy_p_i     (joy_p),
		.joy_pu_i    (joy_pu),
		.joy_a_i     (pad_port[0]),
		.joy_b_i     (pad_port[1])
	);

	// Pad A at index 0, pad B at index 1
	for (genvar i = 0; i < PAD_COUNT; i++) begin : g_pad
		joy_formatter u_joy_formatter (
			.clk_sys    (clk_sys),
			.cold_reset (cold_reset),
			.pad_i      (pad_in[i]),
			.port_o     (pad_port[i]),
			.pad_q_o    (pad_q[i])
		);
	end

	joy_port_ctrl u_joy_port_ctrl (
		.clk_sys    (clk_sys),
		.cold_reset (cold_reset),
		.wr_stb_i   (wr_stb),
		.wr_class_i (wr_class),
		.wr_data_i  (wr_data),
		.wr_addr0_i (wr_addr0),
		.port_a_i   (pad_port[0]),
		.port_b_i   (pad_port[1]),
		.pad_a_i    (pad_q[0]),
		.pad_b_i    (pad_q[1]),
		.joy_p_o    (joy_p),
		.joy_pu_o   (joy_pu)
	);

	edisk_mapper u_edisk_mapper (
		.clk_sys      (clk_sys),
		.cold_reset   (cold_reset),
		.wr_stb_i     (wr_stb),
		.wr_class_i   (wr_class),
		.wr_data_i    (wr_data),
		.mem_addr_i   (mem_addr_i),
		.mem_stack_i  (mem_stack_i),
		.mem_access_i (mem_access_i),
		.ed_page_o    (ed_page_o)
	);

	covox_dac #(
		.COVOX_HOLD_CYCLES (COVOX_HOLD_CYCLES)
	) u_covox_dac (
		.clk_sys      (clk_sys),
		.cold_reset   (cold_reset),
		.rom_enable_i (rom_enable_i),
		.wr_stb_i     (wr_stb),
		.wr_class_i   (wr_class),
		.wr_data_i    (wr_data),
		.covox_o      (covox_o)
	);

endmodule

//--- sim/vector_io_sva.sv
//----------------------------------------------------------
// Bound checks for the Vector 06C I/O block
// Reference model of the port registers, checks on reset
// values, read data, e-disk page, covox and handshake
//----------------------------------------------------------

module vector_io_sva
	import vector_io_pkg::*;
	import vector_joy_pkg::*;
#(
	parameter int unsigned HOLD_CYCLES = 64
) (
	input logic                    clk_sys,
	input logic                    cold_reset,
	input logic                    req_valid_i,
	input logic                    req_ready_o,
	input logic                    req_write_i,
	input port_addr_t              req_addr_i,
	input io_data_t                req_data_i,
	input logic                    rsp_valid_o,
	input logic                    rsp_ready_i,
	input io_data_t                rsp_data_o,
	input pad_t                    pad_a_i,
	input pad_t                    pad_b_i,
	input mem_addr_t               mem_addr_i,
	input logic                    mem_stack_i,
	input logic                    mem_access_i,
	input logic                    rom_enable_i,
	input logic [EDISK_PAGE_W-1:0] ed_page_o,
	input io_data_t                covox_o
);

	int unsigned err_cnt = 0;
	logic        acc;
	io_data_t    ctrl_m;
	io_data_t    ed_m;
	io_data_t    cov_m;
	io_data_t    exp_rsp;
	logic [31:0] hold_m;
	logic        s1_vld;
	logic        s2_vld;
	port_addr_t  s1_addr;
	port_addr_t  s2_addr;
	io_data_t    s1_data;
	io_data_t    s2_data;

	assign acc = req_valid_i && req_ready_o;

	// Active low P-port byte of one pad
	function automatic io_data_t port_byte(input pad_t p);
		return ~{p[PAD_FIRE2], p[PAD_FIRE1], 2'b00,
		         p[PAD_DOWN], p[PAD_UP], p[PAD_LEFT], p[PAD_RIGHT]};
	endfunction

	function automatic io_data_t read_ref(input port_addr_t a, input pad_t pa,
	                                      input pad_t pb, input io_data_t ctrl);
		pad_t     o;
		io_data_t p;
		o = pa | pb;
		case (ctrl[6:5])
			2'b00:   p = port_byte(pa) & port_byte(pb);
			2'b01:   p = port_byte(pa);
			2'b10:   p = port_byte(pb);
			default: p = 8'hFF;
		endcase
		case (a)
			8'h04, 8'h05: return 8'h00;
			8'h06:        return p;
			8'h07:        return {o[PAD_UP], o[PAD_RIGHT], o[PAD_DOWN], o[PAD_LEFT],
			                      o[PAD_FIRE1], o[PAD_FIRE2], 2'b00};
			8'h0E:        return port_byte(pa);
			8'h0F:        return port_byte(pb);
			default:      return 8'hFF;
		endcase
	endfunction

	function automatic logic [EDISK_PAGE_W-1:0] page_ref(input io_data_t r,
	                                                     input mem_addr_t a,
	                                                     input logic stk, input logic acs);
		logic win;
		win = a[15] && ((a[14] != a[13]) || (r[7] && a[14] && a[13]) ||
		                (r[6] && !a[14] && !a[13]));
		if (acs && stk && r[4])
			return {1'b0, r[3:2]} + 3'd1;
		else if (acs && win && r[5])
			return {1'b0, r[1:0]} + 3'd1;
		return '0;
	endfunction

	//----------------------------------------------------------
	// Reference model, writes land two edges after acceptance
	//----------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (cold_reset || rom_enable_i)
			hold_m <= HOLD_CYCLES;
		else if (hold_m != 0)
			hold_m <= hold_m - 1;
		if (cold_reset) begin
			ctrl_m <= '0;
			ed_m   <= '0;
			cov_m  <= '0;
			s1_vld <= 1'b0;
			s2_vld <= 1'b0;
		end else begin
			s1_vld <= acc && req_write_i;
			s2_vld <= s1_vld;
			if (acc && req_write_i && req_addr_i == 8'h05)
				ctrl_m <= req_data_i;
			if (acc && req_write_i && req_addr_i == 8'h04 && !req_data_i[7])
				ctrl_m[req_data_i[3:1]] <= req_data_i[0];
			if (acc && !req_write_i)
				exp_rsp <= read_ref(req_addr_i, pad_a_i, pad_b_i, ctrl_m);
			if (s2_vld && s2_addr == 8'h10)
				ed_m <= s2_data;
			if (s2_vld && s2_addr == 8'h07 && hold_m == 0)
				cov_m <= s2_data;
		end
		s1_addr <= req_addr_i;
		s1_data <= req_data_i;
		s2_addr <= s1_addr;
		s2_data <= s1_data;
	end

	a_reset: assert property (@(posedge clk_sys) cold_reset |=>
		!rsp_valid_o && req_ready_o && covox_o == 8'h00 && ed_page_o == '0)
	else begin
		err_cnt++;
		$error("CHECK FAILED reset state rsp_valid_o=%h req_ready_o=%h covox_o=%h ed_page_o=%h",
		       rsp_valid_o, req_ready_o, covox_o, ed_page_o);
	end

	a_read: assert property (@(posedge clk_sys) disable iff (cold_reset)
		$past(acc && !req_write_i, 2) |-> rsp_valid_o && rsp_data_o == exp_rsp)
	else begin
		err_cnt++;
		$error("CHECK FAILED rsp_data_o got %h expected %h, rsp_valid_o %h",
		       rsp_data_o, exp_rsp, rsp_valid_o);
	end

	a_write_quiet: assert property (@(posedge clk_sys) disable iff (cold_reset)
		$past(acc && req_write_i, 2) |-> !rsp_valid_o)
	else begin
		err_cnt++;
		$error("A write produced a response on the response channel");
	end

	a_rsp_hold: assert property (@(posedge clk_sys) disable iff (cold_reset)
		rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o))
	else begin
		err_cnt++;
		$error("A held response changed or was dropped before it was taken");
	end

	a_stall: assert property (@(posedge clk_sys) disable iff (cold_reset)
		(rsp_valid_o || $past(acc)) |-> !req_ready_o)
	else begin
		err_cnt++;
		$error("CHECK FAILED req_ready_o is %h while a transaction is in flight", req_ready_o);
	end

	a_edisk: assert property (@(posedge clk_sys) disable iff (cold_reset)
		ed_page_o == page_ref(ed_m, mem_addr_i, mem_stack_i, mem_access_i))
	else begin
		err_cnt++;
		$error("CHECK FAILED ed_page_o got %h expected %h", ed_page_o,
		       page_ref(ed_m, mem_addr_i, mem_stack_i, mem_access_i));
	end

	a_covox: assert property (@(posedge clk_sys) disable iff (cold_reset) covox_o == cov_m)
	else begin
		err_cnt++;
		$error("CHECK FAILED covox_o got %h expected %h", covox_o, cov_m);
	end

endmodule

bind vector_io_top vector_io_sva #(
	.HOLD_CYCLES (COVOX_HOLD_CYCLES)
) u_vector_io_sva (.*);

//--- sim/tb_vector_io.sv
//----------------------------------------------------------
// Testbench for the Vector 06C I/O block
// Drives bus transactions, pads and memory-side inputs
//----------------------------------------------------------

module tb_vector_io
	import vector_io_pkg::*;
	import vector_joy_pkg::*;
();

	localparam int unsigned HOLD = 64;
	localparam int TIMEOUT_CYCLES = 200;

	logic                    clk_sys;
	logic                    cold_reset;
	logic                    req_valid_i;
	logic                    req_ready_o;
	logic                    req_write_i;
	port_addr_t              req_addr_i;
	io_data_t                req_data_i;
	logic                    rsp_valid_o;
	logic                    rsp_ready_i;
	io_data_t                rsp_data_o;
	pad_t                    pad_a_i;
	pad_t                    pad_b_i;
	mem_addr_t               mem_addr_i;
	logic                    mem_stack_i;
	logic                    mem_access_i;
	logic                    rom_enable_i;
	logic [EDISK_PAGE_W-1:0] ed_page_o;
	io_data_t                covox_o;
	logic [31:0]             rng;

	vector_io_top #(
		.COVOX_HOLD_CYCLES (HOLD)
	) u_vector_io_top (.*);

	always #4 clk_sys = ~clk_sys;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic abort_timeout(input string what);
		$display("TIMEOUT: %s", what);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on a timeout");
	endtask

	// Returns on the edge where the request is taken
	task automatic issue_req(input logic wr, input port_addr_t addr, input io_data_t data);
		int waited;
		waited = 0;
		@(posedge clk_sys);
		req_valid_i <= 1'b1;
		req_write_i <= wr;
		req_addr_i  <= addr;
		req_data_i  <= data;
		@(negedge clk_sys);
		while (!req_ready_o) begin
			waited++;
			if (waited > TIMEOUT_CYCLES)
				abort_timeout("request was never accepted");
			@(negedge clk_sys);
		end
		@(posedge clk_sys);
		req_valid_i <= 1'b0;
	endtask

	task automatic bus_read(input port_addr_t addr, input int stall);
		int waited;
		waited = 0;
		issue_req(1'b0, addr, 8'h00);
		@(negedge clk_sys);
		while (!rsp_valid_o) begin
			waited++;
			if (waited > TIMEOUT_CYCLES)
				abort_timeout("read response never arrived");
			@(negedge clk_sys);
		end
		repeat (stall) @(posedge clk_sys);
		@(posedge clk_sys);
		rsp_ready_i <= 1'b1;
		@(posedge clk_sys);
		rsp_ready_i <= 1'b0;
	endtask

	task automatic set_pads();
		rng = xorshift32(rng);
		@(posedge clk_sys);
		pad_a_i <= rng[7:0];
		pad_b_i <= rng[15:8];
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic drive_mem(input int cycles);
		repeat (cycles) begin
			rng = xorshift32(rng);
			@(posedge clk_sys);
			mem_addr_i   <= rng[15:0];
			mem_stack_i  <= rng[16];
			mem_access_i <= rng[17] | rng[18];
		end
	endtask

	// First failed assertion ends the run
	always @(negedge clk_sys) begin
		if (u_vector_io_top.u_vector_io_sva.err_cnt != 0) begin
			$display("*** TEST FAILED ***");
			$fatal(1, "bound assertion reported an error");
		end
	end

	initial begin
		int k;
		clk_sys = 1'b0;
		rng = 32'he263_f12c;
		cold_reset   <= 1'b1;
		req_valid_i  <= 1'b0;
		req_write_i  <= 1'b0;
		req_addr_i   <= '0;
		req_data_i   <= '0;
		rsp_ready_i  <= 1'b0;
		pad_a_i      <= '0;
		pad_b_i      <= '0;
		mem_addr_i   <= '0;
		mem_stack_i  <= 1'b0;
		mem_access_i <= 1'b0;
		rom_enable_i <= 1'b0;
		repeat (5) @(posedge clk_sys);
		cold_reset <= 1'b0;

		// Covox write still inside the hold-off after reset
		issue_req(1'b1, 8'h07, 8'h5A);

		for (k = 0; k < 8; k++) begin
			set_pads();
			bus_read(8'h0E, 0);
			bus_read(8'h0F, 0);
			bus_read(8'h07, 0);
			bus_read(8'h06, 0);
			bus_read(rng[31:24], 0);
		end
		bus_read(8'h3C, 0);

		//----------------------------------------------------------
		// P-port select through 05h, then single bits through 04h
		//----------------------------------------------------------
		for (k = 0; k < 4; k++) begin
			rng = xorshift32(rng);
			issue_req(1'b1, 8'h05, {rng[7], k[1:0], rng[4:0]});
			bus_read(8'h06, 0);
			bus_read(8'h05, 0);
		end
		issue_req(1'b1, 8'h05, 8'h00);
		issue_req(1'b1, 8'h04, 8'h0B);
		bus_read(8'h06, 0);
		issue_req(1'b1, 8'h04, 8'h0D);
		bus_read(8'h06, 0);
		issue_req(1'b1, 8'h04, 8'h0A);
		bus_read(8'h06, 0);
		// Bit 7 set makes this write leave bit 6 alone
		issue_req(1'b1, 8'h04, 8'h8C);
		bus_read(8'h06, 0);
		bus_read(8'h04, 0);

		// E-disk register still at its reset value
		drive_mem(32);
		for (k = 0; k < 8; k++) begin
			rng = xorshift32(rng);
			issue_req(1'b1, 8'h10, rng[7:0]);
			drive_mem(32);
		end

		//----------------------------------------------------------
		// Covox hold-off around the boot ROM
		//----------------------------------------------------------
		rom_enable_i <= 1'b1;
		repeat (3) @(posedge clk_sys);
		issue_req(1'b1, 8'h07, 8'hA5);
		@(posedge clk_sys);
		rom_enable_i <= 1'b0;
		// Writes every other cycle across the end of the hold-off
		for (k = 0; k < HOLD / 2 + 8; k++) begin
			rng = xorshift32(rng);
			issue_req(1'b1, 8'h07, rng[7:0]);
		end

		// Responses held back by the testbench
		set_pads();
		bus_read(8'h0E, 6);
		bus_read(8'h07, 3);

		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		if (u_vector_io_top.u_vector_io_sva.err_cnt == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("*** TEST FAILED ***");
			$fatal(1, "errors were reported during the run");
		end
	end

endmodule

//--- sim.f
source/vector_io_pkg.sv
source/vector_joy_pkg.sv
source/io_bus_frontend.sv
source/joy_formatter.sv
source/joy_port_ctrl.sv
source/edisk_mapper.sv
source/covox_dac.sv
source/vector_io_top.sv
sim/vector_io_sva.sv
sim/tb_vector_io.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_vector_io
FILELIST  = sim.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SIM_LOG   = sim.log
RUN_FLAGS = +verilator+error+limit+100
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) $(RUN_FLAGS) > $(SIM_LOG) 2>&1
	@cat $(SIM_LOG)
	@grep -q -F '*** TEST PASSED ***' $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
